// File: compile.f
graph_stage_pkg.sv
graph_topology_pkg.sv
neighbor_link.sv
processing_unit.sv
decoding_graph.sv
tb_decoding_graph.sv
+incdir+.

// File: decoding_graph.sv
`timescale 1ns/10ps

module decoding_graph #(
    parameter int GRID_WIDTH_X = 5,
    parameter int GRID_WIDTH_U = 3,
    parameter int MAX_WEIGHT   = 2
) (
    input  logic                                  clk,
    input  logic                                  rst_n_i,
    input  graph_stage_pkg::stage_e               stage_i,
    input  logic [GRID_WIDTH_X-1:0]               measurements_i,
    output wire  [($clog2(GRID_WIDTH_X) + $clog2(GRID_WIDTH_U))
                  * GRID_WIDTH_X * GRID_WIDTH_U - 1:0] roots_o,
    output wire  [GRID_WIDTH_X*GRID_WIDTH_U-1:0]  busy_o,
    output wire  [(GRID_WIDTH_X+1)*GRID_WIDTH_U
                  + GRID_WIDTH_X*(GRID_WIDTH_U-1) - 1:0] grown_edges_o
);

    localparam int X_BIT_WIDTH     = $clog2(GRID_WIDTH_X);
    localparam int U_BIT_WIDTH     = $clog2(GRID_WIDTH_U);
    localparam int ADDRESS_WIDTH   = X_BIT_WIDTH + U_BIT_WIDTH;
    localparam int PU_COUNT        = GRID_WIDTH_X * GRID_WIDTH_U;
    localparam int ROW_LINK_COUNT  = (GRID_WIDTH_X + 1) * GRID_WIDTH_U;  // Boundaries included

    wire                           unit_meas [PU_COUNT];
    wire [ADDRESS_WIDTH-1:0]       unit_root [PU_COUNT];

    // Row link at position p: end a is unit p-1 (or x=0 on the west boundary)
    wire graph_topology_pkg::link_state_t row_a_state [GRID_WIDTH_U][GRID_WIDTH_X+1];
    wire graph_topology_pkg::link_state_t row_b_state [GRID_WIDTH_U][1:GRID_WIDTH_X-1];
    // Vertical link r: end a in round r, end b in round r+1
    wire graph_topology_pkg::link_state_t vert_a_state [GRID_WIDTH_U-1][GRID_WIDTH_X];
    wire graph_topology_pkg::link_state_t vert_b_state [GRID_WIDTH_U-1][GRID_WIDTH_X];

    for (genvar u = 0; u < GRID_WIDTH_U; u++) begin : g_round
        for (genvar x = 0; x < GRID_WIDTH_X; x++) begin : g_unit
            localparam int IDX  = u * GRID_WIDTH_X + x;
            localparam int ADDR = (u << X_BIT_WIDTH) + x;  // Round above the x field

            wire graph_topology_pkg::link_state_t [graph_topology_pkg::NEIGHBOR_COUNT-1:0]
                slot_state;
            wire [graph_topology_pkg::NEIGHBOR_COUNT-1:0][ADDRESS_WIDTH-1:0] slot_root;
            wire measurement_in;

            if (x == 0) begin : g_west_edge
                assign slot_state[graph_topology_pkg::NEIGHBOR_WEST] = row_a_state[u][0];
                assign slot_root[graph_topology_pkg::NEIGHBOR_WEST]  = ADDRESS_WIDTH'(ADDR);
            end else begin : g_west_unit
                assign slot_state[graph_topology_pkg::NEIGHBOR_WEST] = row_b_state[u][x];
                assign slot_root[graph_topology_pkg::NEIGHBOR_WEST]  = unit_root[IDX-1];
            end

            assign slot_state[graph_topology_pkg::NEIGHBOR_EAST] = row_a_state[u][x+1];
            if (x == GRID_WIDTH_X - 1) begin : g_east_edge
                assign slot_root[graph_topology_pkg::NEIGHBOR_EAST] = ADDRESS_WIDTH'(ADDR);
            end else begin : g_east_unit
                assign slot_root[graph_topology_pkg::NEIGHBOR_EAST] = unit_root[IDX+1];
            end

            if (u == 0) begin : g_oldest
                assign slot_state[graph_topology_pkg::NEIGHBOR_DOWN] = '0;  // No link below
                assign slot_root[graph_topology_pkg::NEIGHBOR_DOWN]  = ADDRESS_WIDTH'(ADDR);
            end else begin : g_below
                assign slot_state[graph_topology_pkg::NEIGHBOR_DOWN] = vert_b_state[u-1][x];
                assign slot_root[graph_topology_pkg::NEIGHBOR_DOWN]  =
                    unit_root[IDX-GRID_WIDTH_X];
            end

            if (u == GRID_WIDTH_U - 1) begin : g_newest
                assign slot_state[graph_topology_pkg::NEIGHBOR_UP] = '0;
                assign slot_root[graph_topology_pkg::NEIGHBOR_UP]  = ADDRESS_WIDTH'(ADDR);
                assign measurement_in = measurements_i[x];  // Fresh round enters here
            end else begin : g_above
                assign slot_state[graph_topology_pkg::NEIGHBOR_UP] = vert_a_state[u][x];
                assign slot_root[graph_topology_pkg::NEIGHBOR_UP]  =
                    unit_root[IDX+GRID_WIDTH_X];
                assign measurement_in = unit_meas[IDX+GRID_WIDTH_X];
            end

            processing_unit #(
                .ADDRESS_WIDTH (ADDRESS_WIDTH),
                .ADDRESS       (ADDR)
            ) u_pu (
                .clk              (clk),
                .rst_n_i          (rst_n_i),
                .stage_i          (stage_i),
                .measurement_i    (measurement_in),
                .neighbor_state_i (slot_state),
                .neighbor_root_i  (slot_root),
                .measurement_o    (unit_meas[IDX]),
                .root_o           (unit_root[IDX]),
                .busy_o           (busy_o[IDX])
            );

            assign roots_o[IDX*ADDRESS_WIDTH +: ADDRESS_WIDTH] = unit_root[IDX];
        end
    end

    for (genvar u = 0; u < GRID_WIDTH_U; u++) begin : g_row_round
        for (genvar p = 0; p <= GRID_WIDTH_X; p++) begin : g_row_link
            localparam int BASE = u * GRID_WIDTH_X;

            if (p == 0 || p == GRID_WIDTH_X) begin : g_boundary
                neighbor_link #(
                    .WEIGHT      (MAX_WEIGHT),
                    .IS_BOUNDARY (1'b1)
                ) u_link (
                    .clk        (clk),
                    .rst_n_i    (rst_n_i),
                    .stage_i    (stage_i),
                    .a_defect_i (unit_meas[BASE + ((p == 0) ? 0 : GRID_WIDTH_X - 1)]),
                    .b_defect_i (1'b0),
                    .a_state_o  (row_a_state[u][p]),
                    .b_state_o  ()
                );
            end else begin : g_internal
                neighbor_link #(
                    .WEIGHT      (MAX_WEIGHT),
                    .IS_BOUNDARY (1'b0)
                ) u_link (
                    .clk        (clk),
                    .rst_n_i    (rst_n_i),
                    .stage_i    (stage_i),
                    .a_defect_i (unit_meas[BASE+p-1]),
                    .b_defect_i (unit_meas[BASE+p]),
                    .a_state_o  (row_a_state[u][p]),
                    .b_state_o  (row_b_state[u][p])
                );
            end

            assign grown_edges_o[u*(GRID_WIDTH_X+1) + p] = row_a_state[u][p].fully_grown;
        end
    end

    for (genvar r = 0; r < GRID_WIDTH_U - 1; r++) begin : g_vert_round
        for (genvar x = 0; x < GRID_WIDTH_X; x++) begin : g_vert_link
            neighbor_link #(
                .WEIGHT      (MAX_WEIGHT),
                .IS_BOUNDARY (1'b0)
            ) u_link (
                .clk        (clk),
                .rst_n_i    (rst_n_i),
                .stage_i    (stage_i),
                .a_defect_i (unit_meas[r*GRID_WIDTH_X + x]),
                .b_defect_i (unit_meas[(r+1)*GRID_WIDTH_X + x]),
                .a_state_o  (vert_a_state[r][x]),
                .b_state_o  (vert_b_state[r][x])
            );

            // Vertical links follow all row links in the report
            assign grown_edges_o[ROW_LINK_COUNT + r*GRID_WIDTH_X + x] =
                vert_a_state[r][x].fully_grown;
        end
    end

endmodule

// File: graph_stage_pkg.sv
package graph_stage_pkg;

    // Width of the global stage code
    localparam int STAGE_WIDTH = 3;

    // Stage broadcast to every unit and link, one action per cycle
    typedef enum logic [STAGE_WIDTH-1:0] {
        STAGE_IDLE  = 3'd0,  // Hold all state
        STAGE_LOAD  = 3'd1,  // Shift measurement rounds down
        STAGE_GROW  = 3'd2,  // Links add defect endpoints
        STAGE_MERGE = 3'd3,  // Units take the smallest reachable root
        STAGE_CLEAR = 3'd4   // Back to own roots and empty links
    } stage_e;

endpackage

// File: graph_topology_pkg.sv
package graph_topology_pkg;

    // Link slots per unit
    localparam int NEIGHBOR_COUNT = 4;

    // Slot index of each direction in a unit's neighbor vectors
    typedef enum logic [1:0] {
        NEIGHBOR_WEST = 2'd0,  // Lower x in the same round
        NEIGHBOR_EAST = 2'd1,  // Higher x in the same round
        NEIGHBOR_DOWN = 2'd2,  // Same x, older round
        NEIGHBOR_UP   = 2'd3   // Same x, newer round
    } neighbor_e;

    // What a link shows to each unit on its ends
    typedef struct packed {
        logic fully_grown;  // Growth reached the weight
        logic is_boundary;  // Far end is a boundary, not a unit
    } link_state_t;

endpackage

// File: neighbor_link.sv
`timescale 1ns/10ps

module neighbor_link #(
    parameter int WEIGHT      = 2,
    parameter bit IS_BOUNDARY = 1'b0
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  graph_stage_pkg::stage_e         stage_i,
    input  logic                            a_defect_i,
    input  logic                            b_defect_i,
    output graph_topology_pkg::link_state_t a_state_o,
    output graph_topology_pkg::link_state_t b_state_o
);

    localparam int GROWTH_WIDTH = $clog2(WEIGHT + 1);

    logic [GROWTH_WIDTH-1:0] growth;
    logic                    b_counted;
    logic [1:0]              increase;
    logic [GROWTH_WIDTH:0]   grown_sum;    // One bit of headroom for the add
    logic                    fully_grown;

    assign b_counted = IS_BOUNDARY ? 1'b0 : b_defect_i;  // Boundary grows from one side
    assign increase  = {1'b0, a_defect_i} + {1'b0, b_counted};
    assign grown_sum = growth + increase;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            growth <= '0;
        end else begin
            case (stage_i)
                graph_stage_pkg::STAGE_GROW: begin
                    if (grown_sum >= WEIGHT) begin
                        growth <= GROWTH_WIDTH'(WEIGHT);  // Saturate at the weight
                    end else begin
                        growth <= grown_sum[GROWTH_WIDTH-1:0];
                    end
                end
                graph_stage_pkg::STAGE_CLEAR: growth <= '0;
                default: growth <= growth;
            endcase
        end
    end

    assign fully_grown = (growth == GROWTH_WIDTH'(WEIGHT));

    assign a_state_o = '{fully_grown: fully_grown, is_boundary: IS_BOUNDARY};
    assign b_state_o = a_state_o;  // Both ends see the same link

    growth_bounded_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        growth <= GROWTH_WIDTH'(WEIGHT));

endmodule

// File: processing_unit.sv
`timescale 1ns/10ps

module processing_unit #(
    parameter int ADDRESS_WIDTH = 6,
    parameter int ADDRESS       = 0
) (
    input  logic                            clk,
    input  logic                            rst_n_i,
    input  graph_stage_pkg::stage_e         stage_i,
    input  logic                            measurement_i,
    input  graph_topology_pkg::link_state_t [graph_topology_pkg::NEIGHBOR_COUNT-1:0]
                                            neighbor_state_i,
    input  logic [graph_topology_pkg::NEIGHBOR_COUNT-1:0][ADDRESS_WIDTH-1:0]
                                            neighbor_root_i,
    output logic                            measurement_o,
    output logic [ADDRESS_WIDTH-1:0]        root_o,
    output logic                            busy_o
);

    localparam logic [ADDRESS_WIDTH-1:0] OWN_ADDRESS = ADDRESS_WIDTH'(ADDRESS);

    logic                                           measurement;
    logic [ADDRESS_WIDTH-1:0]                       root;
    logic                                           busy;
    logic [graph_topology_pkg::NEIGHBOR_COUNT-1:0]  slot_valid;
    logic [ADDRESS_WIDTH-1:0]                       min_root;

    // Measurement register, also the defect flag seen by the links
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            measurement <= 1'b0;
        end else if (stage_i == graph_stage_pkg::STAGE_LOAD) begin
            measurement <= measurement_i;  // Round above or the new vector
        end
    end

    // Only grown links to real units may join roots
    always_comb begin
        for (int n = 0; n < graph_topology_pkg::NEIGHBOR_COUNT; n++) begin
            slot_valid[n] = neighbor_state_i[n].fully_grown
                            && !neighbor_state_i[n].is_boundary;
        end
    end

    always_comb begin
        min_root = root;
        for (int n = 0; n < graph_topology_pkg::NEIGHBOR_COUNT; n++) begin
            if (slot_valid[n] && (neighbor_root_i[n] < min_root)) begin
                min_root = neighbor_root_i[n];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            root <= OWN_ADDRESS;
            busy <= 1'b0;
        end else begin
            case (stage_i)
                graph_stage_pkg::STAGE_MERGE: begin
                    root <= min_root;
                    busy <= (min_root != root);  // Still spreading a smaller root
                end
                graph_stage_pkg::STAGE_CLEAR: begin
                    root <= OWN_ADDRESS;
                    busy <= 1'b0;
                end
                default: begin
                    busy <= 1'b0;
                end
            endcase
        end
    end

    assign measurement_o = measurement;
    assign root_o        = root;
    assign busy_o        = busy;

    // A cluster root is always the smallest member, never above our own address
    root_bounded_a: assert property (@(posedge clk) disable iff (!rst_n_i)
        root <= OWN_ADDRESS);

endmodule

// File: tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

int root_errors  = 0;
int busy_errors  = 0;
int edge_errors  = 0;
int other_errors = 0;

task automatic check_roots(input string test_name, input logic [AW*PU-1:0] expected,
                           input logic [AW*PU-1:0] actual);
    if (actual !== expected) begin
        root_errors++;
        $display("error: %s roots expected %h actual %h", test_name, expected, actual);
    end
endtask

task automatic check_busy(input string test_name, input logic [PU-1:0] expected,
                          input logic [PU-1:0] actual);
    if (actual !== expected) begin
        busy_errors++;
        $display("error: %s busy expected %b actual %b", test_name, expected, actual);
    end
endtask

task automatic check_edges(input string test_name, input logic [EDGES-1:0] expected,
                           input logic [EDGES-1:0] actual);
    if (actual !== expected) begin
        edge_errors++;
        $display("error: %s edges expected %b actual %b", test_name, expected, actual);
    end
endtask

function automatic int error_total();
    return root_errors + busy_errors + edge_errors + other_errors;
endfunction

`endif

// File: tb_decoding_graph.sv
`timescale 1ns/10ps

module tb_decoding_graph;

    localparam int GX        = 5;
    localparam int GU        = 3;
    localparam int MW        = 2;
    localparam int XB        = $clog2(GX);
    localparam int AW        = XB + $clog2(GU);
    localparam int PU        = GX * GU;
    localparam int ROWL      = (GX + 1) * GU;
    localparam int EDGES     = ROWL + GX * (GU - 1);
    localparam int MERGE_LEN = GX * GU + 2;
    // Upper bound of reset plus all tests, in cycles
    localparam int TEST_CYCLES = 16 + 5 * (GU + 2 + MW + MERGE_LEN) + 20 * (5 + MERGE_LEN);

    logic                    clk;
    logic                    rst_n_i;
    graph_stage_pkg::stage_e stage_i;
    logic [GX-1:0]           measurements_i;
    wire  [AW*PU-1:0]        roots_o;
    wire  [PU-1:0]           busy_o;
    wire  [EDGES-1:0]        grown_edges_o;

    logic [GX-1:0] model_meas [GU];  // Measurements per round
    int            grow_cycles;       // GROW edges since the last clear
    int            cycle_count = 0;

    `include "tb_checks.svh"

    decoding_graph #(.GRID_WIDTH_X(GX), .GRID_WIDTH_U(GU), .MAX_WEIGHT(MW)) dut0 (
        .clk(clk), .rst_n_i(rst_n_i), .stage_i(stage_i), .measurements_i(measurements_i),
        .roots_o(roots_o), .busy_o(busy_o), .grown_edges_o(grown_edges_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= 2 * TEST_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", 2 * TEST_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [EDGES-1:0] expected_edges();
        logic [EDGES-1:0] edges;
        int               defects;
        edges = '0;
        for (int u = 0; u < GU; u++) begin
            for (int p = 0; p <= GX; p++) begin
                if (p == 0) defects = int'(model_meas[u][0]);  // West boundary
                else if (p == GX) defects = int'(model_meas[u][GX-1]);
                else defects = int'(model_meas[u][p-1]) + int'(model_meas[u][p]);
                edges[u*(GX+1)+p] = (grow_cycles * defects >= MW);
            end
        end
        for (int r = 0; r < GU - 1; r++) begin
            for (int x = 0; x < GX; x++) begin
                defects = int'(model_meas[r][x]) + int'(model_meas[r+1][x]);
                edges[ROWL+r*GX+x] = (grow_cycles * defects >= MW);
            end
        end
        return edges;
    endfunction

    // Component minimum by relaxing over grown internal links
    function automatic logic [AW*PU-1:0] expected_roots();
        logic [EDGES-1:0] edges;
        logic [AW-1:0]    root [PU];
        logic [AW*PU-1:0] packed_roots;
        int               a;
        int               b;
        edges = expected_edges();
        for (int i = 0; i < PU; i++) root[i] = AW'(((i / GX) << XB) + i % GX);
        repeat (PU) begin
            for (int e = 0; e < EDGES; e++) begin
                if (!edges[e]) continue;
                if (e < ROWL) begin
                    if (e % (GX + 1) == 0 || e % (GX + 1) == GX) continue;  // Boundary
                    a = (e / (GX + 1)) * GX + e % (GX + 1) - 1;
                    b = a + 1;
                end else begin
                    a = e - ROWL;
                    b = a + GX;
                end
                if (root[a] < root[b]) root[b] = root[a];
                else root[a] = root[b];
            end
        end
        for (int i = 0; i < PU; i++) packed_roots[i*AW +: AW] = root[i];
        return packed_roots;
    endfunction

    task automatic apply_stage(input graph_stage_pkg::stage_e stage, input int cycles);
        stage_i = stage;
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
        stage_i = graph_stage_pkg::STAGE_IDLE;
    endtask

    task automatic load_vector(input logic [GX-1:0] vector);
        measurements_i = vector;
        apply_stage(graph_stage_pkg::STAGE_LOAD, 1);
        for (int k = 0; k < GU - 1; k++) model_meas[k] = model_meas[k+1];
        model_meas[GU-1] = vector;  // Newest round on top
    endtask

    task automatic grow_for(input int cycles);
        apply_stage(graph_stage_pkg::STAGE_GROW, cycles);
        grow_cycles += cycles;
    endtask

    task automatic clear_graph();
        apply_stage(graph_stage_pkg::STAGE_CLEAR, 1);
        grow_cycles = 0;
    endtask

    task automatic merge_to_idle(input string test_name);
        int edges_seen;
        edges_seen = 0;
        stage_i = graph_stage_pkg::STAGE_MERGE;
        do begin
            @(posedge clk);
            #1;
            edges_seen++;
        end while (busy_o !== '0 && edges_seen < MERGE_LEN);
        stage_i = graph_stage_pkg::STAGE_IDLE;
        if (busy_o !== '0) begin
            other_errors++;
            $display("%s: merge still busy after %0d cycles", test_name, edges_seen);
        end
    endtask

    task automatic reset_defaults();
        check_roots("after_reset", expected_roots(), roots_o);
        check_busy("after_reset", '0, busy_o);
        check_edges("after_reset", '0, grown_edges_o);
    endtask

    task automatic load_shift_rounds();
        load_vector(5'b10110);
        load_vector(5'b01001);
        load_vector(5'b11100);
        grow_for(MW);
        check_edges("load_shift", expected_edges(), grown_edges_o);
    endtask

    task automatic growth_saturation();
        clear_graph();
        repeat (GU - 1) load_vector('0);
        load_vector(5'b00001);  // One defect at the west end of the top round
        grow_for(1);
        check_edges("saturation_first", '0, grown_edges_o);
        grow_for(1);
        check_edges("saturation_second", expected_edges(), grown_edges_o);
        grow_for(2);
        check_edges("saturation_hold", expected_edges(), grown_edges_o);
    endtask

    task automatic merge_components();
        clear_graph();
        load_vector(5'b00110);
        load_vector(5'b00011);
        load_vector(5'b10001);
        grow_for(MW);
        apply_stage(graph_stage_pkg::STAGE_MERGE, MERGE_LEN);
        check_roots("merge", expected_roots(), roots_o);
        check_busy("merge", '0, busy_o);
    endtask

    task automatic clear_then_regrow();
        logic [EDGES-1:0] edges_before;
        edges_before = expected_edges();
        clear_graph();
        check_roots("clear", expected_roots(), roots_o);
        check_edges("clear", '0, grown_edges_o);
        check_busy("clear", '0, busy_o);
        grow_for(MW);
        check_edges("regrow", edges_before, grown_edges_o);
    endtask

    task automatic random_rounds();
        string test_name;
        for (int i = 0; i < 20; i++) begin
            test_name = $sformatf("random_%0d", i);
            clear_graph();
            load_vector(GX'($urandom));
            grow_for($urandom % 4);
            check_edges(test_name, expected_edges(), grown_edges_o);
            merge_to_idle(test_name);
            check_roots(test_name, expected_roots(), roots_o);
            check_busy(test_name, '0, busy_o);
        end
    endtask

    initial begin
        void'($urandom(32'h1b77ed73));
        rst_n_i        = 1'b0;
        stage_i        = graph_stage_pkg::STAGE_IDLE;
        measurements_i = '0;
        grow_cycles    = 0;
        for (int k = 0; k < GU; k++) model_meas[k] = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        reset_defaults();
        load_shift_rounds();
        growth_saturation();
        merge_components();
        clear_then_regrow();
        random_rounds();
        $display("Errors: roots %0d, busy %0d, edges %0d, other %0d",
                 root_errors, busy_errors, edge_errors, other_errors);
        if (error_total() == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
